/* common/nand_pkg.sv */
`default_nettype none

package nand_pkg;

    // Host operation select with code 3 unsupported
    typedef enum logic [1:0] {
        OP_WRITE = 2'd0,
        OP_READ  = 2'd1,
        OP_ERASE = 2'd2
    } nand_op_e;

    // ONFI command bytes used by the tester
    typedef enum logic [7:0] {
        CMD_READ     = 8'h00,
        CMD_READ_GO  = 8'h30,
        CMD_PROG     = 8'h80,
        CMD_PROG_GO  = 8'h10,
        CMD_ERASE    = 8'h60,
        CMD_ERASE_GO = 8'hD0,
        CMD_STATUS   = 8'h70
    } nand_cmd_e;

    // Source of the byte placed on DQ
    typedef enum logic [1:0] {
        DQ_SRC_CMD     = 2'd0,
        DQ_SRC_ADDR    = 2'd1,
        DQ_SRC_PATTERN = 2'd2
    } dq_src_e;

    localparam int ADDR_BYTES         = 5;  // Two column plus three row cycles
    localparam int ERASE_FIRST_ADDR   = 2;  // Erase skips the column bytes
    localparam int CMD_WAIT_CYCLES    = 10; // tADL, tWHR, tRR
    localparam int READ_SETTLE_CYCLES = 6;  // RE low before DQ is trusted
    localparam int MIN_BUSY_CYCLES    = 10; // Covers tWB

endpackage

`default_nettype wire

/* source/busy_timer.sv */
`timescale 1ns/1ps
`default_nettype none

module busy_timer (
    input  wire         CLK,
    input  wire         RST,
    input  wire         wait_active,
    input  wire         rb,
    output logic        rb_ready,
    output logic [31:0] latency
);
    import nand_pkg::*;

    logic        wait_d;
    logic        rb_q;    // R/B is asynchronous to CLK
    logic [31:0] lat_cnt;

    // First wait cycle is excluded so an old count never passes the check
    assign rb_ready = wait_active && wait_d && rb_q &&
                      (lat_cnt >= 32'(MIN_BUSY_CYCLES - 1));
    assign latency  = lat_cnt;

    always_ff @(posedge CLK)
    begin
        rb_q <= rb;
        if (RST)
        begin
            wait_d  <= 1'b0;
            lat_cnt <= 32'd0;
        end
        else
        begin
            wait_d <= wait_active;
            if (wait_active && !wait_d)
                lat_cnt <= 32'd1;               // Wait starts
            else if (wait_active)
                lat_cnt <= lat_cnt + 32'd1;     // Holds once wait ends
        end
    end

endmodule

`default_nettype wire

/* source/page_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module page_checker #(
    parameter int PAGE_SIZE = 9168
) (
    input  wire         CLK,
    input  wire         RST,
    input  wire [((PAGE_SIZE > 1) ? $clog2(PAGE_SIZE) : 1)-1:0] byte_index,
    input  wire         inverse_pattern,
    input  wire         pattern_usr_0,
    input  wire [7:0]   pattern_0,
    input  wire         pattern_usr_1,
    input  wire [7:0]   pattern_1,
    input  wire         check_clear,
    input  wire         check_sample,
    input  wire         status_capture,
    input  wire [7:0]   dq_in,
    output logic [7:0]  pattern_byte,
    output logic [31:0] badbits
);
    logic [7:0]  idx_ext;
    logic [7:0]  diff;
    logic [3:0]  diff_count;

    assign idx_ext = 8'(byte_index); // Short indices zero-extend

    always_comb
    begin
        if (inverse_pattern)
            pattern_byte = pattern_usr_1 ? pattern_1 : ~idx_ext;
        else
            pattern_byte = pattern_usr_0 ? pattern_0 : idx_ext;
    end

    assign diff = dq_in ^ pattern_byte;

    always_comb
    begin
        diff_count = 4'd0;
        for (int b = 0; b < 8; b++)
            diff_count = diff_count + 4'(diff[b]);
    end

    always_ff @(posedge CLK)
    begin
        if (RST || check_clear)
            badbits <= 32'd0;
        else if (status_capture)
            badbits <= {24'd0, dq_in};              // Status byte replaces the count
        else if (check_sample)
            badbits <= badbits + 32'(diff_count);
    end

endmodule

`default_nettype wire

/* nand_ctrl/nand_bus_io.sv */
`timescale 1ns/1ps
`default_nettype none

module nand_bus_io (
    input  wire                     CLK,
    input  wire                     RST,
    input  wire nand_pkg::dq_src_e  dq_src,
    input  wire nand_pkg::nand_cmd_e cmd_byte,
    input  wire [2:0]               addr_index,
    input  wire [39:0]              addr,
    input  wire [7:0]               pattern_byte,
    input  wire                     dq_load,
    input  wire                     dq_oe,
    output logic [7:0]              dq_in,
    inout  wire [7:0]               dq
);
    import nand_pkg::*;

    logic [7:0] addr_byte;
    logic [7:0] dq_sel;
    logic [7:0] dq_out;

    // Most significant address byte goes out first
    always_comb
    begin
        case (addr_index)
            3'd0:    addr_byte = addr[39:32];
            3'd1:    addr_byte = addr[31:24];
            3'd2:    addr_byte = addr[23:16];
            3'd3:    addr_byte = addr[15:8];
            default: addr_byte = addr[7:0];
        endcase
    end

    always_comb
    begin
        case (dq_src)
            DQ_SRC_ADDR:    dq_sel = addr_byte;
            DQ_SRC_PATTERN: dq_sel = pattern_byte;
            default:        dq_sel = cmd_byte;
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RST)
            dq_out <= 8'h00;
        else if (dq_load)
            dq_out <= dq_sel; // Stable before WE falls
    end

    assign dq = dq_oe ? dq_out : 8'bzzzz_zzzz;

    // Sampled every cycle and used only in the controller's sample cycle
    always_ff @(posedge CLK)
    begin
        dq_in <= dq;
    end

endmodule

`default_nettype wire

/* nand_ctrl/nand_op_fsm.sv */
`timescale 1ns/1ps
`default_nettype none

module nand_op_fsm #(
    parameter int PAGE_SIZE = 9168
) (
    input  wire                  CLK,
    input  wire                  RST,
    input  wire                  start,
    input  wire nand_pkg::nand_op_e oper,
    input  wire                  rb_ready,
    output logic                 done,
    output logic                 cle,
    output logic                 ale,
    output logic                 we_n,
    output logic                 re_n,
    output nand_pkg::dq_src_e    dq_src,
    output nand_pkg::nand_cmd_e  cmd_byte,
    output logic [2:0]           addr_index,
    output logic                 dq_load,
    output logic                 dq_oe,
    output logic                 wait_active,
    output logic [((PAGE_SIZE > 1) ? $clog2(PAGE_SIZE) : 1)-1:0] byte_index,
    output logic                 check_clear,
    output logic                 check_sample,
    output logic                 status_capture
);
    import nand_pkg::*;

    localparam int IDX_W = (PAGE_SIZE > 1) ? $clog2(PAGE_SIZE) : 1;

    typedef enum logic [4:0] {
        S_IDLE, S_CMD1_SET, S_CMD1_HI, S_ADDR_SET, S_ADDR_HI, S_WAIT_ADL,
        S_DIN_SET, S_DIN_HI, S_DIN_HOLD, S_CMD2_SET, S_CMD2_HI, S_BUSY,
        S_STAT_SET, S_STAT_HI, S_WAIT_WHR, S_WAIT_RR, S_DOUT_LOW, S_DOUT_SAMPLE,
        S_DONE
    } state_e;

    state_e           state;
    state_e           state_next;
    logic [2:0]       addr_cnt;
    logic [3:0]       wait_cnt;
    logic [IDX_W-1:0] data_cnt;
    logic             stat_mode;   // Current read phase is the status byte
    logic             wait_last;
    logic             settle_last;
    logic             last_byte;

    assign wait_last   = (wait_cnt == 4'(CMD_WAIT_CYCLES - 1));
    assign settle_last = (wait_cnt == 4'(READ_SETTLE_CYCLES - 1));
    assign last_byte   = (data_cnt == IDX_W'(PAGE_SIZE - 1));

    always_comb
    begin
        state_next = state;
        case (state)
            S_IDLE:        if (start)
                               state_next = (oper inside {OP_WRITE, OP_READ, OP_ERASE}) ?
                                            S_CMD1_SET : S_DONE;
            S_CMD1_SET:    state_next = S_CMD1_HI;
            S_CMD1_HI:     state_next = S_ADDR_SET;
            S_ADDR_SET:    state_next = S_ADDR_HI;
            S_ADDR_HI:
                if (addr_cnt != 3'(ADDR_BYTES))
                    state_next = S_ADDR_SET;
                else
                    state_next = (oper == OP_WRITE) ? S_WAIT_ADL : S_CMD2_SET;
            S_WAIT_ADL:    if (wait_last) state_next = S_DIN_SET;
            S_DIN_SET:     state_next = S_DIN_HI;
            S_DIN_HI:      state_next = S_DIN_HOLD;
            S_DIN_HOLD:    state_next = (data_cnt == '0) ? S_CMD2_SET : S_DIN_SET; // Wrapped
            S_CMD2_SET:    state_next = S_CMD2_HI;
            S_CMD2_HI:     state_next = S_BUSY;
            S_BUSY:        if (rb_ready) state_next = (oper == OP_READ) ? S_WAIT_RR : S_STAT_SET;
            S_STAT_SET:    state_next = S_STAT_HI;
            S_STAT_HI:     state_next = S_WAIT_WHR;
            S_WAIT_WHR,
            S_WAIT_RR:     if (wait_last) state_next = S_DOUT_LOW;
            S_DOUT_LOW:    if (settle_last) state_next = S_DOUT_SAMPLE;
            S_DOUT_SAMPLE: state_next = (stat_mode || last_byte) ? S_DONE : S_DOUT_LOW;
            S_DONE:        if (!start) state_next = S_IDLE;
            default:       state_next = S_IDLE;
        endcase
    end

    // Bus register loads in the cycle before each WE falling edge
    assign dq_load = state_next inside {S_CMD1_SET, S_ADDR_SET, S_DIN_SET, S_CMD2_SET, S_STAT_SET};

    always_comb
    begin
        case (state_next)
            S_ADDR_SET: dq_src = DQ_SRC_ADDR;
            S_DIN_SET:  dq_src = DQ_SRC_PATTERN;
            default:    dq_src = DQ_SRC_CMD;
        endcase
        case (state_next)
            S_CMD2_SET: cmd_byte = (oper == OP_READ)  ? CMD_READ_GO :
                                   (oper == OP_ERASE) ? CMD_ERASE_GO : CMD_PROG_GO;
            S_STAT_SET: cmd_byte = CMD_STATUS;
            default:    cmd_byte = (oper == OP_READ)  ? CMD_READ :
                                   (oper == OP_ERASE) ? CMD_ERASE : CMD_PROG;
        endcase
    end

    assign addr_index     = addr_cnt;
    assign byte_index     = data_cnt;
    assign check_clear    = (state == S_IDLE) && start;
    assign check_sample   = (state == S_DOUT_SAMPLE) && !stat_mode;
    assign status_capture = (state == S_DOUT_SAMPLE) && stat_mode;

    always_ff @(posedge CLK)
    begin
        if (RST)
        begin
            state       <= S_IDLE;
            done        <= 1'b0;
            cle         <= 1'b0;
            ale         <= 1'b0;
            we_n        <= 1'b1;
            re_n        <= 1'b1;
            dq_oe       <= 1'b0;
            wait_active <= 1'b0;
            stat_mode   <= 1'b0;
            addr_cnt    <= 3'd0;
            wait_cnt    <= 4'd0;
            data_cnt    <= '0;
        end
        else
        begin
            state <= state_next;

            // Pin levels follow the state being entered
            cle  <= state_next inside {S_CMD1_SET, S_CMD1_HI, S_CMD2_SET, S_CMD2_HI,
                                       S_STAT_SET, S_STAT_HI};
            ale  <= state_next inside {S_ADDR_SET, S_ADDR_HI};
            we_n <= !(state_next inside {S_CMD1_SET, S_ADDR_SET, S_DIN_SET, S_CMD2_SET,
                                         S_STAT_SET});
            re_n <= (state_next != S_DOUT_LOW);
            dq_oe <= state_next inside {S_CMD1_SET, S_CMD1_HI, S_ADDR_SET, S_ADDR_HI,
                                        S_WAIT_ADL, S_DIN_SET, S_DIN_HI, S_DIN_HOLD,
                                        S_CMD2_SET, S_CMD2_HI, S_STAT_SET, S_STAT_HI};
            wait_active <= (state_next == S_BUSY);
            done        <= (state_next == S_DONE);

            if (state == S_IDLE)
                stat_mode <= 1'b0;
            else if (state_next == S_STAT_SET)
                stat_mode <= 1'b1;

            if (state == S_IDLE)
                addr_cnt <= (oper == OP_ERASE) ? 3'(ERASE_FIRST_ADDR) : 3'd0;
            else if (state == S_ADDR_SET)
                addr_cnt <= addr_cnt + 3'd1; // Points at next byte during HI

            if (state_next == state &&
                state inside {S_WAIT_ADL, S_WAIT_WHR, S_WAIT_RR, S_DOUT_LOW})
                wait_cnt <= wait_cnt + 4'd1;
            else
                wait_cnt <= 4'd0;

            if (state == S_IDLE)
                data_cnt <= '0;
            else if (state == S_DIN_HI || state == S_DOUT_SAMPLE)
                data_cnt <= last_byte ? '0 : data_cnt + 1'b1;
        end
    end

endmodule

`default_nettype wire

/* source/nand_tester.sv */
`timescale 1ns/1ps
`default_nettype none

module nand_tester #(
    parameter int PAGE_SIZE = 9168
) (
    input  wire                 CLK,
    input  wire                 RST,
    input  wire                 start,
    input  wire nand_pkg::nand_op_e oper,
    input  wire [39:0]          addr,
    input  wire                 inverse_pattern,
    input  wire                 pattern_usr_0,
    input  wire [7:0]           pattern_0,
    input  wire                 pattern_usr_1,
    input  wire [7:0]           pattern_1,
    output logic                done,
    output logic [31:0]         latency,
    output logic [31:0]         badbits,
    output logic                cle,
    output logic                ale,
    output logic                we_n,
    output logic                re_n,
    input  wire                 rb,
    inout  wire [7:0]           dq
);
    import nand_pkg::*;

    localparam int IDX_W = (PAGE_SIZE > 1) ? $clog2(PAGE_SIZE) : 1;

    dq_src_e          dq_src;
    nand_cmd_e        cmd_byte;
    logic [2:0]       addr_index;
    logic             dq_load;
    logic             dq_oe;
    logic             wait_active;
    logic             rb_ready;
    logic [IDX_W-1:0] byte_index;
    logic             check_clear;
    logic             check_sample;
    logic             status_capture;
    logic [7:0]       pattern_byte;
    logic [7:0]       dq_in;

    nand_op_fsm #(
        .PAGE_SIZE (PAGE_SIZE)
    ) i_nand_op_fsm (
        .CLK            (CLK),
        .RST            (RST),
        .start          (start),
        .oper           (oper),
        .rb_ready       (rb_ready),
        .done           (done),
        .cle            (cle),
        .ale            (ale),
        .we_n           (we_n),
        .re_n           (re_n),
        .dq_src         (dq_src),
        .cmd_byte       (cmd_byte),
        .addr_index     (addr_index),
        .dq_load        (dq_load),
        .dq_oe          (dq_oe),
        .wait_active    (wait_active),
        .byte_index     (byte_index),
        .check_clear    (check_clear),
        .check_sample   (check_sample),
        .status_capture (status_capture)
    );

    nand_bus_io i_nand_bus_io (
        .CLK          (CLK),
        .RST          (RST),
        .dq_src       (dq_src),
        .cmd_byte     (cmd_byte),
        .addr_index   (addr_index),
        .addr         (addr),
        .pattern_byte (pattern_byte),
        .dq_load      (dq_load),
        .dq_oe        (dq_oe),
        .dq_in        (dq_in),
        .dq           (dq)
    );

    busy_timer i_busy_timer (
        .CLK         (CLK),
        .RST         (RST),
        .wait_active (wait_active),
        .rb          (rb),
        .rb_ready    (rb_ready),
        .latency     (latency)
    );

    page_checker #(
        .PAGE_SIZE (PAGE_SIZE)
    ) i_page_checker (
        .CLK             (CLK),
        .RST             (RST),
        .byte_index      (byte_index),
        .inverse_pattern (inverse_pattern),
        .pattern_usr_0   (pattern_usr_0),
        .pattern_0       (pattern_0),
        .pattern_usr_1   (pattern_usr_1),
        .pattern_1       (pattern_1),
        .check_clear     (check_clear),
        .check_sample    (check_sample),
        .status_capture  (status_capture),
        .dq_in           (dq_in),
        .pattern_byte    (pattern_byte),
        .badbits         (badbits)
    );

endmodule

`default_nettype wire

/* sim/nand_flash_model.sv */
`timescale 1ns/1ps
`default_nettype none

module nand_flash_model #(
    parameter int PAGE_SIZE = 16
) (
    input  wire        CLK,
    input  wire        cle,
    input  wire        ale,
    input  wire        we_n,
    input  wire        re_n,
    output wire        rb,
    inout  wire [7:0]  dq,
    input  wire [31:0] busy_cycles,
    input  wire [23:0] flip_row,
    input  wire [7:0]  flip_col,
    input  wire [7:0]  flip_mask   // Zero disables bit flips
);
    logic [7:0]  mem [logic [31:0]];  // Keyed by {row, column}
    logic [23:0] row_sr      = '0;
    logic [7:0]  col         = '0;
    logic        status_mode = 1'b0;
    logic        we_q        = 1'b1;
    logic        re_q        = 1'b1;
    logic [31:0] busy_left   = '0;
    logic [7:0]  rd_byte     = 8'hFF;

    // Erased cells read as all ones
    function automatic logic [7:0] stored_byte(input logic [23:0] row, input logic [7:0] c);
        if (mem.exists({row, c}))
            return mem[{row, c}];
        return 8'hFF;
    endfunction

    assign rb = (busy_left == 32'd0);
    assign dq = re_n ? 8'bzzzz_zzzz : rd_byte;

    // WE and RE edges line up with CLK, so they are seen one clock later
    always @(posedge CLK)
    begin
        we_q <= we_n;
        re_q <= re_n;
        if (busy_left != 32'd0)
            busy_left <= busy_left - 32'd1;

        if (we_n && !we_q)
        begin
            if (cle)
            begin
                case (dq)
                    8'h00, 8'h80:
                    begin
                        col         <= 8'd0;
                        status_mode <= 1'b0;
                    end
                    8'h10, 8'h30:
                    begin
                        col         <= 8'd0;
                        status_mode <= 1'b0;
                        busy_left   <= busy_cycles;
                    end
                    8'hD0:
                    begin
                        for (int c = 0; c < PAGE_SIZE; c++)
                            mem.delete({row_sr, 8'(c)});
                        busy_left <= busy_cycles;
                    end
                    8'h70:   status_mode <= 1'b1;
                    default: ;
                endcase
            end
            else if (ale)
                row_sr <= {row_sr[15:0], dq}; // Last three bytes form the row
            else
            begin
                mem[{row_sr, col}] = stored_byte(row_sr, col) & dq; // Program only clears bits
                col <= col + 8'd1;
            end
        end

        if (re_n && !re_q && !status_mode)
            col <= col + 8'd1;

        rd_byte <= status_mode ? 8'hE0 :
                   stored_byte(row_sr, col) ^
                   ((row_sr == flip_row && col == flip_col) ? flip_mask : 8'h00);
    end

endmodule

`default_nettype wire

/* sim/nand_tester_assert.sv */
`timescale 1ns/1ps
`default_nettype none

module nand_tester_assert (
    input wire CLK,
    input wire RST,
    input wire cle,
    input wire ale,
    input wire we_n,
    input wire re_n,
    input wire dq_oe
);
    we_re_exclusive: assert property (@(posedge CLK) disable iff (RST) we_n || re_n)
        else $error("WE and RE are low in the same cycle");

    cle_ale_exclusive: assert property (@(posedge CLK) disable iff (RST) !(cle && ale))
        else $error("CLE and ALE are high in the same cycle");

    // Device owns DQ while RE is low
    no_drive_on_read: assert property (@(posedge CLK) disable iff (RST) re_n || !dq_oe)
        else $error("DQ is driven while RE is low");

endmodule

bind nand_op_fsm nand_tester_assert i_nand_tester_assert (
    .CLK   (CLK),
    .RST   (RST),
    .cle   (cle),
    .ale   (ale),
    .we_n  (we_n),
    .re_n  (re_n),
    .dq_oe (dq_oe)
);

`default_nettype wire

/* sim/tb_nand_tester.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_nand_tester;
    import nand_pkg::*;

    localparam int PAGE_SIZE  = 16;
    localparam int CLK_PERIOD = 8;
    localparam int BUSY_MAX   = 40;
    // Longest operation is a page read with 7 cycles per byte plus busy, waits and commands
    localparam int OP_CYCLES  = 60 + 10 * PAGE_SIZE + BUSY_MAX;
    localparam int NUM_OPS    = 11;
    localparam int MAX_CYCLES = NUM_OPS * OP_CYCLES + 100;
    localparam logic [23:0] ROW_A = 24'h000123;
    localparam logic [23:0] ROW_B = 24'h000456;

    logic        CLK;
    logic        RST;
    logic        start;
    nand_op_e    oper;
    logic [39:0] addr;
    logic        inverse_pattern;
    logic        pattern_usr_0;
    logic [7:0]  pattern_0;
    logic        pattern_usr_1;
    logic [7:0]  pattern_1;
    wire         done;
    wire  [31:0] latency;
    wire  [31:0] badbits;
    wire         cle;
    wire         ale;
    wire         we_n;
    wire         re_n;
    wire         rb;
    wire  [7:0]  dq;
    logic [31:0] busy_cycles;
    logic [23:0] flip_row;
    logic [7:0]  flip_col;
    logic [7:0]  flip_mask;
    int          errors       = 0;
    int          tests_failed = 0;
    int          cycle_count  = 0;
    int          seed         = 32'h338ae442;

    nand_tester #(
        .PAGE_SIZE (PAGE_SIZE)
    ) i_nand_tester (
        .CLK             (CLK),
        .RST             (RST),
        .start           (start),
        .oper            (oper),
        .addr            (addr),
        .inverse_pattern (inverse_pattern),
        .pattern_usr_0   (pattern_usr_0),
        .pattern_0       (pattern_0),
        .pattern_usr_1   (pattern_usr_1),
        .pattern_1       (pattern_1),
        .done            (done),
        .latency         (latency),
        .badbits         (badbits),
        .cle             (cle),
        .ale             (ale),
        .we_n            (we_n),
        .re_n            (re_n),
        .rb              (rb),
        .dq              (dq)
    );

    nand_flash_model #(
        .PAGE_SIZE (PAGE_SIZE)
    ) i_flash (
        .CLK         (CLK),
        .cle         (cle),
        .ale         (ale),
        .we_n        (we_n),
        .re_n        (re_n),
        .rb          (rb),
        .dq          (dq),
        .busy_cycles (busy_cycles),
        .flip_row    (flip_row),
        .flip_col    (flip_col),
        .flip_mask   (flip_mask)
    );

    initial
    begin
        CLK = 1'b0;
        forever #(CLK_PERIOD / 2) CLK = ~CLK;
    end

    initial
    begin
        while (cycle_count < MAX_CYCLES)
        begin
            @(posedge CLK);
            cycle_count++;
        end
        $display("Timeout: the tests did not finish within %0d clock cycles", MAX_CYCLES);
        $display("Simulation failed");
        $finish;
    end

    // Bus rules checked half a cycle after each edge
    always @(negedge CLK)
    begin
        if (!RST)
        begin
            assert ((we_n || re_n) && !(cle && ale) && (re_n || !i_nand_tester.dq_oe))
            else
            begin
                $display("[FAIL] %0t ns: NAND bus protocol broken, cle=%b ale=%b we_n=%b re_n=%b",
                         $time, cle, ale, we_n, re_n);
                $display("Simulation failed");
                $finish;
            end
        end
    end

    function automatic int count_ones(input logic [7:0] v);
        int n;
        n = 0;
        for (int b = 0; b < 8; b++)
            if (v[b])
                n++;
        return n;
    endfunction

    task automatic check_equal(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got == exp)
        else
        begin
            $display("[FAIL] %0t ns: %s is 0x%0h, expected 0x%0h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic within_range(input string what, input logic [31:0] got,
                                input logic [31:0] lo, input logic [31:0] hi);
        assert (got >= lo && got <= hi)
        else
        begin
            $display("[FAIL] %0t ns: %s is %0d, expected %0d to %0d", $time, what, got, lo, hi);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int err0);
        if (errors == err0)
            $display("%s: passed", name);
        else
        begin
            tests_failed++;
            $display("%s: failed with %0d errors", name, errors - err0);
        end
    endtask

    // Reset is held for three cycles and start drops as it is released
    task automatic apply_reset;
        @(negedge CLK);
        RST = 1'b1;
        repeat (3) @(negedge CLK);
        RST   = 1'b0;
        start = 1'b0;
    endtask

    task automatic set_pattern(input logic inv, input logic usr0, input logic [7:0] p0,
                               input logic usr1, input logic [7:0] p1);
        inverse_pattern = inv;
        pattern_usr_0   = usr0;
        pattern_0       = p0;
        pattern_usr_1   = usr1;
        pattern_1       = p1;
    endtask

    task automatic start_op(input nand_op_e op, input logic [23:0] row, input int busy);
        @(negedge CLK);
        oper        = op;
        addr        = {16'h0000, row};
        busy_cycles = busy;
        start       = 1'b1;
    endtask

    // Start an operation and return once done is seen
    task automatic run_op(input nand_op_e op, input logic [23:0] row, input int busy);
        start_op(op, row, busy);
        @(negedge CLK);
        while (!done)
            @(negedge CLK);
    endtask

    task automatic release_op;
        @(negedge CLK);
        start = 1'b0;
        @(negedge CLK);
    endtask

    task automatic test_write_status;
        int err0;
        err0 = errors;
        set_pattern(1'b0, 1'b0, 8'h00, 1'b0, 8'h00);
        run_op(OP_WRITE, ROW_A, 40);
        check_equal("write status", badbits, 32'hE0);
        within_range("write latency", latency, 32'd40, 32'd43);
        release_op();
        report_test("test_write_status", err0);
    endtask

    task automatic test_read_clean;
        int err0;
        err0 = errors;
        run_op(OP_READ, ROW_A, 20);
        check_equal("clean read bit errors", badbits, 32'd0);
        release_op();
        report_test("test_read_clean", err0);
    endtask

    task automatic test_read_errors;
        int err0;
        err0 = errors;
        flip_row  = ROW_A;
        flip_col  = 8'd5;
        flip_mask = 8'b1000_0101;
        run_op(OP_READ, ROW_A, 20);
        check_equal("injected bit errors", badbits, 32'(count_ones(flip_mask)));
        release_op();
        flip_mask = 8'h00;
        report_test("test_read_errors", err0);
    endtask

    task automatic test_user_inverse;
        int          err0;
        int          expected;
        logic [7:0]  p1;
        err0     = errors;
        expected = 0;
        p1       = 8'($random(seed));
        set_pattern(1'b1, 1'b0, 8'h00, 1'b1, p1);
        run_op(OP_WRITE, ROW_B, 20);
        check_equal("user write status", badbits, 32'hE0);
        release_op();
        set_pattern(1'b0, 1'b0, 8'h00, 1'b0, 8'h00);
        for (int i = 0; i < PAGE_SIZE; i++)
            expected += count_ones(p1 ^ 8'(i));
        run_op(OP_READ, ROW_B, 20);
        check_equal("user pattern bit errors", badbits, 32'(expected));
        release_op();
        report_test("test_user_inverse", err0);
    endtask

    task automatic test_erase_latency;
        int err0;
        err0 = errors;
        run_op(OP_ERASE, ROW_A, 3);
        check_equal("erase status", badbits, 32'hE0);
        within_range("erase latency", latency, 32'(MIN_BUSY_CYCLES), 32'(MIN_BUSY_CYCLES + 3));
        release_op();
        set_pattern(1'b0, 1'b1, 8'hFF, 1'b0, 8'h00); // Erased page reads all ones
        run_op(OP_READ, ROW_A, 20);
        check_equal("erased page bit errors", badbits, 32'd0);
        release_op();
        report_test("test_erase_latency", err0);
    endtask

    task automatic test_done_handshake;
        int err0;
        err0 = errors;
        set_pattern(1'b0, 1'b0, 8'h00, 1'b0, 8'h00);
        run_op(OP_ERASE, ROW_B, 10); // done, status and latency all set
        apply_reset();
        check_equal("done after reset", {31'd0, done}, 32'd0);
        check_equal("latency after reset", latency, 32'd0);
        check_equal("badbits after reset", badbits, 32'd0);
        run_op(OP_READ, ROW_A, 10);
        repeat (5)
        begin
            @(negedge CLK);
            check_equal("done while start held", {31'd0, done}, 32'd1);
        end
        release_op();
        check_equal("done after start dropped", {31'd0, done}, 32'd0);
        start_op(OP_READ, ROW_A, 10);
        while (re_n)
            @(negedge CLK);
        apply_reset();                // Reset in the middle of a page read
        check_equal("cle ale we_n re_n after reset", {28'd0, cle, ale, we_n, re_n}, 32'h3);
        report_test("test_done_handshake", err0);
    endtask

    initial
    begin
        RST = 1'b1;
        start = 1'b0;
        oper = OP_WRITE;
        addr = 40'd0;
        set_pattern(1'b0, 1'b0, 8'h00, 1'b0, 8'h00);
        busy_cycles = 32'd10;
        flip_row = 24'd0;
        flip_col = 8'd0;
        flip_mask = 8'h00;
        apply_reset();

        test_write_status();
        test_read_clean();
        test_read_errors();
        test_user_inverse();
        test_erase_latency();
        test_done_handshake();

        $display("Tests run: 6, tests failed: %0d, checks failed: %0d", tests_failed, errors);
        if (errors == 0)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

/* tb.f */
common/nand_pkg.sv
source/busy_timer.sv
source/page_checker.sv
nand_ctrl/nand_bus_io.sv
nand_ctrl/nand_op_fsm.sv
source/nand_tester.sv
sim/nand_flash_model.sv
sim/nand_tester_assert.sv
sim/tb_nand_tester.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_nand_tester
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Simulation completed successfully

.PHONY: test clean help

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS PASS_MSG"
